// File: all.f
+incdir+.
flags_rename_pkg.sv
flags_bus_pkg.sv
flags_write_arbiter.sv
flags_entry_buf.sv
flags_read_port.sv
flags_rename_table.sv
tb_flags_rename_table.sv

// File: Makefile
TOP = tb_flags_rename_table

.PHONY: sim clean

sim:
	verilator --binary --assert --timescale 1ns/10ps -f all.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -x "Everything OK" > /dev/null

clean:
	rm -rf obj_dir

// File: tb_flags_cases.svh
// Stimulus and expected values for the flags rename table testbench.
// Columns: read_en, read_thread, addr0, addr1 / write_thread, {slot2, slot1, slot0}, rnd,
// ret_thread, {port2, port1, port0}, retire_all, byp0, byp1 / exp0, exp1, exp_committed.

  task automatic build_cases();
    // Reset state of both threads.
    add_row(1, 0, 14, 13,
            0, '0, 0, 0, '0, 0, NO_BYP, NO_BYP,
            entry(0, 9, 1), entry(0, 9, 1), entry(0, 9, 1));
    add_row(1, 1, 14, 14,
            0, '0, 0, 0, '0, 0, NO_BYP, NO_BYP,
            entry(0, 9, 1), entry(0, 9, 1), entry(0, 9, 1));
    // Slots 0 and 1 write thread 0, slot 1 is youngest.
    add_row(1, 0, 14, 15,
            0, {wslot(0, 'h013, 'h023), wslot(1, 'h012, 'h022), wslot(1, 'h011, 'h021)},
            0, 0, '0, 0, NO_BYP, NO_BYP,
            entry('h012, 'h022, 0), entry(0, 0, 0), entry('h012, 'h022, 0));
    add_row(1, 1, 14, 13,
            0, '0, 0, 0, '0, 0, NO_BYP, NO_BYP,
            entry(0, 9, 1), entry(0, 9, 1), entry(0, 9, 1));
    // All slots write thread 1, index inputs move without read_en.
    add_row(0, 0, 0, 0,
            1, {wslot(1, 'h1a5, 'h2c7), wslot(1, 'h102, 'h3f2), wslot(1, 'h101, 'h3f1)},
            0, 0, '0, 0, NO_BYP, NO_BYP,
            entry('h1a5, 'h2c7, 0), entry('h1a5, 'h2c7, 1), entry('h1a5, 'h2c7, 0));
    add_row(0, 0, 0, 0,
            0, '0, 0, 1, {IDLE_PORT, rport(0, 'h1a5), rport(1, 'h1a4)}, 0, NO_BYP, NO_BYP,
            entry('h1a5, 'h2c7, 0), entry('h1a5, 'h2c7, 1), entry('h1a5, 'h2c7, 0));
    add_row(0, 0, 0, 0,
            0, '0, 0, 0, {IDLE_PORT, IDLE_PORT, rport(1, 'h1a5)}, 0, NO_BYP, NO_BYP,
            entry('h1a5, 'h2c7, 0), entry('h1a5, 'h2c7, 1), entry('h1a5, 'h2c7, 0));
    // Matching retire and write to thread 1 in one cycle.
    add_row(0, 0, 0, 0,
            1, {IDLE_SLOT, IDLE_SLOT, wslot(1, 'h0c3, 'h155)},
            0, 1, {rport(1, 'h1a5), IDLE_PORT, IDLE_PORT}, 0, NO_BYP, NO_BYP,
            entry('h0c3, 'h155, 0), entry('h0c3, 'h155, 1), entry('h0c3, 'h155, 0));
    add_row(0, 0, 0, 0,
            0, {wslot(1, 'h077, 'h0ee), IDLE_SLOT, IDLE_SLOT},
            0, 1, {IDLE_PORT, rport(1, 'h0c3), IDLE_PORT}, 0, NO_BYP, NO_BYP,
            entry('h0c3, 'h155, 1), entry('h0c3, 'h155, 1), entry('h0c3, 'h155, 1));
    // Rewrite thread 1, then retire_all on thread 0 only.
    add_row(1, 0, 14, 13,
            1, {IDLE_SLOT, wslot(1, 'h0aa, 'h1bb), IDLE_SLOT}, 0, 0, '0, 0, NO_BYP, NO_BYP,
            entry('h077, 'h0ee, 0), entry('h077, 'h0ee, 1), entry('h077, 'h0ee, 0));
    add_row(0, 0, 0, 0,
            0, '0, 0, 0, '0, 1, NO_BYP, NO_BYP,
            entry('h077, 'h0ee, 1), entry('h077, 'h0ee, 1), entry('h077, 'h0ee, 1));
    add_row(1, 1, 14, 13,
            0, '0, 0, 0, '0, 0, NO_BYP, NO_BYP,
            entry('h0aa, 'h1bb, 0), entry('h0aa, 'h1bb, 1), entry('h0aa, 'h1bb, 0));
    add_row(0, 0, 0, 0,
            0, '0, 0, 1, '0, 1, NO_BYP, NO_BYP,
            entry('h0aa, 'h1bb, 1), entry('h0aa, 'h1bb, 1), entry('h0aa, 'h1bb, 1));
    // Bypass of random slot data.
    add_row(1, 1, 0, 2,
            0, '0, 1, 0, '0, 0, 0, 2,
            entry(0, 0, 0), entry(0, 0, 0), entry('h0aa, 'h1bb, 1));
    add_row(1, 1, 1, 3,
            0, '0, 1, 0, '0, 0, 1, NO_BYP,
            entry(0, 0, 0), entry(0, 0, 0), entry('h0aa, 'h1bb, 1));
    add_row(0, 0, 14, 13,
            0, '0, 1, 0, '0, 0, 1, NO_BYP,
            entry(0, 0, 0), entry(0, 0, 0), entry('h0aa, 'h1bb, 1));
    add_row(1, 0, 14, 13,
            0, '0, 0, 0, '0, 0, NO_BYP, NO_BYP,
            entry('h077, 'h0ee, 1), entry('h077, 'h0ee, 1), entry('h077, 'h0ee, 1));
    add_row(1, 0, 12, 15,
            0, '0, 0, 0, '0, 0, NO_BYP, NO_BYP,
            entry(0, 0, 0), entry(0, 0, 0), entry('h077, 'h0ee, 1));
  endtask

// File: tb_flags_rename_table.sv
// Testbench for the flags rename table.
// Applies a table of per-cycle stimulus and checks read results and the committed entry.
`timescale 1ns/10ps
`default_nettype none

module tb_flags_rename_table;

  localparam int         CLK_PERIOD = 8;
  localparam logic [1:0] NO_BYP     = 2'd3; // Compare against the table value.

  localparam flags_bus_pkg::new_slot_t IDLE_SLOT = '0;
  localparam flags_bus_pkg::ret_port_t IDLE_PORT = '0;

  typedef struct packed {
    logic                                                           read_en;
    logic                                                           read_thread;
    flags_rename_pkg::arch_idx_t [flags_rename_pkg::READ_PORTS-1:0] read_addr;
    logic                                                           write_thread;
    flags_bus_pkg::new_slot_t [flags_rename_pkg::NEW_SLOTS-1:0]     slots;
    logic                                                           rnd; // Random slot data.
    logic                                                           ret_thread;
    flags_bus_pkg::ret_port_t [flags_rename_pkg::RET_PORTS-1:0]     rets;
    logic                                                           retire_all;
    logic [flags_rename_pkg::READ_PORTS-1:0][1:0]                   byp;
    flags_bus_pkg::flags_entry_t [flags_rename_pkg::READ_PORTS-1:0] exp_result;
    flags_bus_pkg::flags_entry_t                                    exp_committed;
  } case_t;

  logic                                                           clk = 1'b0;
  logic                                                           rst = 1'b1;
  logic                                                           read_en = 1'b0;
  logic                                                           read_thread = 1'b0;
  flags_rename_pkg::arch_idx_t [flags_rename_pkg::READ_PORTS-1:0] read_addr = '0;
  logic                                                           write_thread = 1'b0;
  flags_bus_pkg::new_slot_t [flags_rename_pkg::NEW_SLOTS-1:0]     new_slots = '0;
  logic                                                           ret_thread = 1'b0;
  flags_bus_pkg::ret_port_t [flags_rename_pkg::RET_PORTS-1:0]     ret_ports = '0;
  logic                                                           retire_all = 1'b0;
  flags_bus_pkg::flags_entry_t [flags_rename_pkg::READ_PORTS-1:0] read_result;
  flags_bus_pkg::flags_entry_t                                    committed;

  case_t cases[$];
  int    errors = 0;
  int    checks = 0;

  function automatic flags_bus_pkg::new_slot_t wslot(input logic wen,
                                                     input flags_rename_pkg::tag_t tag,
                                                     input flags_rename_pkg::funit_t funit);
    flags_bus_pkg::new_slot_t s;
    s.wen   = wen;
    s.tag   = tag;
    s.funit = funit;
    return s;
  endfunction

  function automatic flags_bus_pkg::ret_port_t rport(input logic wen,
                                                     input flags_rename_pkg::tag_t tag);
    flags_bus_pkg::ret_port_t p;
    p.wen = wen;
    p.tag = tag;
    return p;
  endfunction

  function automatic flags_bus_pkg::flags_entry_t entry(input flags_rename_pkg::tag_t tag,
                                                        input flags_rename_pkg::funit_t funit,
                                                        input logic retired);
    flags_bus_pkg::flags_entry_t e;
    e.tag     = tag;
    e.funit   = funit;
    e.retired = retired;
    return e;
  endfunction

  task automatic add_row(
    input logic ren, input logic rthr,
    input flags_rename_pkg::arch_idx_t a0, input flags_rename_pkg::arch_idx_t a1,
    input logic wthr, input flags_bus_pkg::new_slot_t [flags_rename_pkg::NEW_SLOTS-1:0] sl,
    input logic rnd, input logic retthr,
    input flags_bus_pkg::ret_port_t [flags_rename_pkg::RET_PORTS-1:0] rp,
    input logic rall, input logic [1:0] b0, input logic [1:0] b1,
    input flags_bus_pkg::flags_entry_t e0, input flags_bus_pkg::flags_entry_t e1,
    input flags_bus_pkg::flags_entry_t ec);
    case_t c;
    c.read_en       = ren;
    c.read_thread   = rthr;
    c.read_addr[0]  = a0;
    c.read_addr[1]  = a1;
    c.write_thread  = wthr;
    c.slots         = sl;
    c.rnd           = rnd;
    c.ret_thread    = retthr;
    c.rets          = rp;
    c.retire_all    = rall;
    c.byp[0]        = b0;
    c.byp[1]        = b1;
    c.exp_result[0] = e0;
    c.exp_result[1] = e1;
    c.exp_committed = ec;
    cases.push_back(c);
  endtask

  `include "tb_flags_cases.svh"

  task automatic apply_row(input int idx);
    case_t c;
    c = cases[idx];
    if (c.rnd)
    begin
      for (int j = 0; j < flags_rename_pkg::NEW_SLOTS; j++)
      begin
        c.slots[j].tag   = flags_rename_pkg::tag_t'($urandom);
        c.slots[j].funit = flags_rename_pkg::funit_t'($urandom);
      end
    end
    read_en      = c.read_en;
    read_thread  = c.read_thread;
    read_addr    = c.read_addr;
    write_thread = c.write_thread;
    new_slots    = c.slots;
    ret_thread   = c.ret_thread;
    ret_ports    = c.rets;
    retire_all   = c.retire_all;
  endtask

  // Bypass rows expect the slot data still driven on new_slots.
  task automatic check_row(input int idx);
    case_t                       c;
    flags_bus_pkg::flags_entry_t expected;
    c = cases[idx];
    for (int k = 0; k < flags_rename_pkg::READ_PORTS; k++)
    begin
      if (c.byp[k] == NO_BYP)
      begin
        expected = c.exp_result[k];
      end
      else
      begin
        expected = entry(new_slots[c.byp[k]].tag, new_slots[c.byp[k]].funit, 1'b0);
      end
      checks++;
      assert (read_result[k] === expected)
      else
      begin
        $display("FAILED row %0d: read_result[%0d] = %h, expected %h",
                 idx, k, read_result[k], expected);
        errors++;
      end
    end
    checks++;
    assert (committed === c.exp_committed)
    else
    begin
      $display("FAILED row %0d: committed = %h, expected %h", idx, committed, c.exp_committed);
      errors++;
    end
  endtask

  flags_rename_table i_flags_rename_table (
    .clk          (clk),
    .rst          (rst),
    .read_en      (read_en),
    .read_thread  (read_thread),
    .read_addr    (read_addr),
    .write_thread (write_thread),
    .new_slots    (new_slots),
    .ret_thread   (ret_thread),
    .ret_ports    (ret_ports),
    .retire_all   (retire_all),
    .read_result  (read_result),
    .committed    (committed)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  initial
  begin
    void'($urandom(32'h80d1));
    build_cases();
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    foreach (cases[i])
    begin
      apply_row(i);
      @(posedge clk);
      #0.5; // Outputs settled, row inputs still held.
      check_row(i);
      #0.5;
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
    begin
      $display("Everything OK");
    end
    else
    begin
      $display("Something failed");
    end
    $finish;
  end

  initial
  begin
    int unsigned limit_ns;
    #1;
    limit_ns = (cases.size() + 10) * CLK_PERIOD;
    #(limit_ns);
    $display("Timeout: the table did not finish within %0d ns", limit_ns);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: flags_rename_table.sv
// Flags rename table top.
// Write arbiter, per-thread entry buffer and the read ports.
`timescale 1ns/10ps
`default_nettype none

module flags_rename_table (
  input  logic                                                           clk,
  input  logic                                                           rst,
  input  logic                                                           read_en,
  input  logic                                                           read_thread,
  input  flags_rename_pkg::arch_idx_t [flags_rename_pkg::READ_PORTS-1:0] read_addr,
  input  logic                                                           write_thread,
  input  flags_bus_pkg::new_slot_t [flags_rename_pkg::NEW_SLOTS-1:0]     new_slots,
  input  logic                                                           ret_thread,
  input  flags_bus_pkg::ret_port_t [flags_rename_pkg::RET_PORTS-1:0]     ret_ports,
  input  logic                                                           retire_all,
  output flags_bus_pkg::flags_entry_t [flags_rename_pkg::READ_PORTS-1:0] read_result,
  output flags_bus_pkg::flags_entry_t                                    committed
);

  logic                        write_valid;
  flags_bus_pkg::flags_entry_t write_data;
  flags_bus_pkg::flags_entry_t committed_int;

  flags_write_arbiter i_arbiter (
    .new_slots   (new_slots),
    .write_valid (write_valid),
    .write_data  (write_data)
  );

  flags_entry_buf i_entry_buf (
    .clk          (clk),
    .rst          (rst),
    .write_thread (write_thread),
    .write_valid  (write_valid),
    .write_data   (write_data),
    .ret_thread   (ret_thread),
    .ret_ports    (ret_ports),
    .retire_all   (retire_all),
    .read_en      (read_en),
    .read_thread  (read_thread),
    .committed    (committed_int)
  );

  // One read port per source operand.
  for (genvar k = 0; k < flags_rename_pkg::READ_PORTS; k++)
  begin : g_read_port
    flags_read_port i_read_port (
      .clk         (clk),
      .rst         (rst),
      .read_en     (read_en),
      .read_addr   (read_addr[k]),
      .new_slots   (new_slots),
      .committed   (committed_int),
      .read_result (read_result[k])
    );
  end

  assign committed = committed_int;

endmodule

`default_nettype wire

// File: flags_read_port.sv
// Flags read port.
// Registers a source index and returns the committed entry or a bundle bypass.
`timescale 1ns/10ps
`default_nettype none

module flags_read_port (
  input  logic                                                        clk,
  input  logic                                                        rst,
  input  logic                                                        read_en,
  input  flags_rename_pkg::arch_idx_t                                 read_addr,
  input  flags_bus_pkg::new_slot_t [flags_rename_pkg::NEW_SLOTS-1:0] new_slots,
  input  flags_bus_pkg::flags_entry_t                                 committed,
  output flags_bus_pkg::flags_entry_t                                 read_result
);

  flags_rename_pkg::arch_idx_t addr_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      addr_q <= '0;
    end
    else if (read_en)
    begin
      addr_q <= read_addr;
    end
  end

  // Index j below the slot count bypasses slot j, enabled or not.
  always_comb
  begin
    read_result = '0;
    if (addr_q == flags_rename_pkg::FLAGS_IDX)
    begin
      read_result = committed;
    end
    else if (addr_q == flags_rename_pkg::FLAGS_RETIRED_IDX)
    begin
      read_result         = committed;
      read_result.retired = 1'b1; // Caller knows the producer is done.
    end
    else
    begin
      for (int j = 0; j < flags_rename_pkg::NEW_SLOTS; j++)
      begin
        if (addr_q == flags_rename_pkg::arch_idx_t'(j))
        begin
          read_result.tag   = new_slots[j].tag;
          read_result.funit = new_slots[j].funit;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: flags_entry_buf.sv
// Flags entry buffer.
// Per-thread producer tag, unit and retired bit, with retire matching
// and the registered read thread.
`timescale 1ns/10ps
`default_nettype none

module flags_entry_buf (
  input  logic                                                        clk,
  input  logic                                                        rst,
  input  logic                                                        write_thread,
  input  logic                                                        write_valid,
  input  flags_bus_pkg::flags_entry_t                                 write_data,
  input  logic                                                        ret_thread,
  input  flags_bus_pkg::ret_port_t [flags_rename_pkg::RET_PORTS-1:0]  ret_ports,
  input  logic                                                        retire_all,
  input  logic                                                        read_en,
  input  logic                                                        read_thread,
  output flags_bus_pkg::flags_entry_t                                 committed
);

  flags_bus_pkg::flags_entry_t entries [flags_rename_pkg::THREADS];
  flags_bus_pkg::flags_entry_t entry_d [flags_rename_pkg::THREADS];

  logic [flags_rename_pkg::THREADS-1:0] ret_match;  // Some retire port hits this tag.
  logic [flags_rename_pkg::THREADS-1:0] write_sel;
  logic [flags_rename_pkg::THREADS-1:0] retire_sel;
  logic                                 read_thread_q;

  // Compare every enabled retire port against each thread's stored tag.
  always_comb
  begin
    ret_match = '0;
    for (int t = 0; t < flags_rename_pkg::THREADS; t++)
    begin
      for (int p = 0; p < flags_rename_pkg::RET_PORTS; p++)
      begin
        if (ret_ports[p].wen && (ret_ports[p].tag == entries[t].tag))
        begin
          ret_match[t] = 1'b1;
        end
      end
    end
  end

  always_comb
  begin
    for (int t = 0; t < flags_rename_pkg::THREADS; t++)
    begin
      write_sel[t]  = write_valid && (write_thread == 1'(t));
      retire_sel[t] = (ret_thread == 1'(t)) && (retire_all || ret_match[t]);
    end
  end

  // A write to a thread beats a retire to the same thread.
  always_comb
  begin
    for (int t = 0; t < flags_rename_pkg::THREADS; t++)
    begin
      entry_d[t] = entries[t];
      if (write_sel[t])
      begin
        entry_d[t] = write_data;
      end
      else if (retire_sel[t])
      begin
        entry_d[t].retired = 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int t = 0; t < flags_rename_pkg::THREADS; t++)
      begin
        entries[t].tag     <= '0;
        entries[t].funit   <= flags_rename_pkg::RESET_FUNIT;
        entries[t].retired <= 1'b1; // Architectural state.
      end
      read_thread_q <= 1'b0;
    end
    else
    begin
      for (int t = 0; t < flags_rename_pkg::THREADS; t++)
      begin
        entries[t] <= entry_d[t];
      end
      if (read_en)
      begin
        read_thread_q <= read_thread;
      end
    end
  end

  assign committed = entries[read_thread_q];

endmodule

`default_nettype wire

// File: flags_write_arbiter.sv
// Flags write arbiter.
// Puts the youngest writing bundle slot onto the single entry write path.
`timescale 1ns/10ps
`default_nettype none

module flags_write_arbiter (
  input  flags_bus_pkg::new_slot_t [flags_rename_pkg::NEW_SLOTS-1:0] new_slots,
  output logic                                                        write_valid,
  output flags_bus_pkg::flags_entry_t                                 write_data
);

  logic [flags_rename_pkg::NEW_SLOTS-1:0] slot_wen;

  always_comb
  begin
    for (int i = 0; i < flags_rename_pkg::NEW_SLOTS; i++)
    begin
      slot_wen[i] = new_slots[i].wen;
    end
  end

  assign write_valid = |slot_wen;

  // Later slots override earlier ones, so the highest index wins.
  always_comb
  begin
    write_data = '0;
    for (int i = 0; i < flags_rename_pkg::NEW_SLOTS; i++)
    begin
      if (slot_wen[i])
      begin
        write_data.tag   = new_slots[i].tag;
        write_data.funit = new_slots[i].funit;
      end
    end
    write_data.retired = 1'b0; // Fresh producer.
  end

endmodule

`default_nettype wire

// File: flags_bus_pkg.sv
// Flags rename bus structs.
// Write slot, retire port and stored entry layouts.
`default_nettype none

package flags_bus_pkg;

  // One rename bundle slot.
  typedef struct packed {
    logic                      wen;
    flags_rename_pkg::tag_t    tag;
    flags_rename_pkg::funit_t  funit;
  } new_slot_t;

  // One retire port.
  typedef struct packed {
    logic                      wen;
    flags_rename_pkg::tag_t    tag;
  } ret_port_t;

  // Flags entry as stored and as returned to readers.
  typedef struct packed {
    flags_rename_pkg::tag_t    tag;
    flags_rename_pkg::funit_t  funit;
    logic                      retired; // Producer has left the window.
  } flags_entry_t;

endpackage

`default_nettype wire

// File: flags_rename_pkg.sv
// Flags rename entry widths and constants.
// Sizes of the rename bundle, retire ports and read ports, and reserved indices.
`default_nettype none

package flags_rename_pkg;

  localparam int TAG_W      = 9;
  localparam int FUNIT_W    = 10;
  localparam int ARCH_IDX_W = 4;

  // Producer tag, the free register number.
  typedef logic [TAG_W-1:0] tag_t;

  typedef logic [FUNIT_W-1:0] funit_t;      // Functional-unit code.
  typedef logic [ARCH_IDX_W-1:0] arch_idx_t; // Architectural source index.

  localparam int NEW_SLOTS  = 3; // Rename bundle slots.
  localparam int RET_PORTS  = 3;
  localparam int READ_PORTS = 2;
  localparam int THREADS    = 2;

  // Source indices that read the committed entry.
  localparam arch_idx_t FLAGS_IDX         = 4'd14;
  localparam arch_idx_t FLAGS_RETIRED_IDX = 4'd13;

  localparam funit_t RESET_FUNIT = 10'd9; // Unit code held after reset.

endpackage

`default_nettype wire
